// File: logic/backEndSpaceCheck.sv
// Occupancy inputs must stay within capacity and a lane is never both a load and a store
`timescale 1ns/1ps

module backEndSpaceCheck (
  input  logic                 clk,
  input  logic                 rstN_i,
  input  logic                 isLoad_i  [dispatchPkg::DISPATCH_WIDTH],
  input  logic                 isStore_i [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::lsqCnt_t loadQueueCnt_i,   // Entries in use in the load queue
  input  dispatchPkg::lsqCnt_t storeQueueCnt_i,  // Entries in use in the store queue
  input  dispatchPkg::iqCnt_t  issueQueueCnt_i,
  input  dispatchPkg::alCnt_t  activeListCnt_i,
  output logic                 spaceStall_o
);

  logic [dispatchPkg::DISPATCH_WIDTH-1:0] loadVec;   // Packed copy of the lane flags
  logic [dispatchPkg::DISPATCH_WIDTH-1:0] storeVec;
  dispatchPkg::laneCnt_t                  loadCnt;
  dispatchPkg::laneCnt_t                  storeCnt;
  logic                                   loadFull;
  logic                                   storeFull;
  logic                                   issueFull;
  logic                                   activeFull;

  always_comb begin : countLdSt
    loadCnt  = '0;
    storeCnt = '0;
    for (int l = 0; l < dispatchPkg::DISPATCH_WIDTH; l++) begin
      loadVec[l]  = isLoad_i[l];
      storeVec[l] = isStore_i[l];
      loadCnt     = loadCnt + dispatchPkg::laneCnt_t'(isLoad_i[l]);
      storeCnt    = storeCnt + dispatchPkg::laneCnt_t'(isStore_i[l]);
    end
  end

  // LSQ needs room only for the memory ops of the group
  assign loadFull   = (int'(loadQueueCnt_i) + int'(loadCnt)) > dispatchPkg::SIZE_LSQ;
  assign storeFull  = (int'(storeQueueCnt_i) + int'(storeCnt)) > dispatchPkg::SIZE_LSQ;

  // Issue queue and active list reserve a full group regardless of contents
  assign issueFull  = (int'(issueQueueCnt_i) + dispatchPkg::DISPATCH_WIDTH)
                      > dispatchPkg::SIZE_ISSUEQ;
  assign activeFull = (int'(activeListCnt_i) + dispatchPkg::DISPATCH_WIDTH)
                      > dispatchPkg::SIZE_ACTIVELIST;

  assign spaceStall_o = loadFull | storeFull | issueFull | activeFull;  // Exact fit still passes

  // The back end never reports more entries in use than it has
  occWithinCap: assert property (@(posedge clk) disable iff (!rstN_i)
    (loadQueueCnt_i <= dispatchPkg::SIZE_LSQ) &&
    (storeQueueCnt_i <= dispatchPkg::SIZE_LSQ) &&
    (issueQueueCnt_i <= dispatchPkg::SIZE_ISSUEQ) &&
    (activeListCnt_i <= dispatchPkg::SIZE_ACTIVELIST))
    else $error("[FAIL] occupancy lq=%0h sq=%0h iq=%0h al=%0h", loadQueueCnt_i,
                storeQueueCnt_i, issueQueueCnt_i, activeListCnt_i);

  // Rename marks each memory op as exactly one kind
  ldStExclusive: assert property (@(posedge clk) disable iff (!rstN_i)
    (loadVec & storeVec) == '0)
    else $error("[FAIL] lanes %0h flagged load and store", loadVec & storeVec);

endmodule

// File: logic/branchMaskUpdate.sv
// Only one branch verifies per cycle and ctrlVerifiedId_i is ignored while ctrlVerified_i is low
`timescale 1ns/1ps

module branchMaskUpdate (
  input  dispatchPkg::branchMask_t branchMask_i [dispatchPkg::DISPATCH_WIDTH],
  input  logic                     ctrlVerified_i,
  input  dispatchPkg::ckptId_t     ctrlVerifiedId_i,
  output dispatchPkg::branchMask_t branchMask_o [dispatchPkg::DISPATCH_WIDTH]
);

  dispatchPkg::branchMask_t clearMask;  // One-hot bit of the verified checkpoint

  always_comb begin : buildClear
    clearMask = '0;
    if (ctrlVerified_i) begin
      clearMask[ctrlVerifiedId_i] = 1'b1;
    end
  end

  // The same clear applies to every lane of the group
  always_comb begin : applyClear
    for (int l = 0; l < dispatchPkg::DISPATCH_WIDTH; l++) begin
      branchMask_o[l] = branchMask_i[l] & ~clearMask;  // Other checkpoints pass through
    end
  end

endmodule

// File: logic/dispatch.sv
// Accepts a whole group or nothing; outputs follow acceptance by one cycle and stall_i freezes them
`timescale 1ns/1ps

module dispatch (
  input  logic                     clk,
  input  logic                     rstN_i,
  input  logic                     stall_i,          // Back end cannot take the latched group
  input  logic                     renameReady_i,    // Group present from rename
  input  logic                     flagRecoverEX_i,  // Execute is redirecting the pipe
  input  logic                     ctrlVerified_i,
  input  dispatchPkg::ckptId_t     ctrlVerifiedId_i,
  input  dispatchPkg::pc_t         pc_i          [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::opcode_t     opcode_i      [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::imm_t        imm_i         [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::logReg_t     logDest_i     [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::physReg_t    physSrc1_i    [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::physReg_t    physSrc2_i    [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::physReg_t    physDest_i    [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::physReg_t    physOldDest_i [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::ckptId_t     ckptId_i      [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::branchMask_t branchMask_i  [dispatchPkg::DISPATCH_WIDTH],
  input  logic                     isLoad_i      [dispatchPkg::DISPATCH_WIDTH],
  input  logic                     isStore_i     [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::lsqCnt_t     loadQueueCnt_i,
  input  dispatchPkg::lsqCnt_t     storeQueueCnt_i,
  input  dispatchPkg::iqCnt_t      issueQueueCnt_i,
  input  dispatchPkg::alCnt_t      activeListCnt_i,
  output logic                     backEndReady_o,   // Group accepted on this edge
  output logic                     stallFrontEnd_o,
  output dispatchPkg::branchMask_t updatedBranchMask_o [dispatchPkg::DISPATCH_WIDTH],
  output logic                     dispatchValid_o,
  output dispatchPkg::pc_t         pc_o          [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::opcode_t     opcode_o      [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::imm_t        imm_o         [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::logReg_t     logDest_o     [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::physReg_t    physSrc1_o    [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::physReg_t    physSrc2_o    [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::physReg_t    physDest_o    [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::physReg_t    physOldDest_o [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::ckptId_t     ckptId_o      [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::branchMask_t branchMask_o  [dispatchPkg::DISPATCH_WIDTH],
  output logic                     isLoad_o      [dispatchPkg::DISPATCH_WIDTH],
  output logic                     isStore_o     [dispatchPkg::DISPATCH_WIDTH]
);

  logic spaceStall;  // Some back-end structure lacks room for the group

  // Updated masks go back to the rename/dispatch register and into the latch
  branchMaskUpdate maskUpdate_i (
    .branchMask_i     (branchMask_i),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlVerifiedId_i (ctrlVerifiedId_i),
    .branchMask_o     (updatedBranchMask_o)
  );

  backEndSpaceCheck spaceCheck_i (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .isLoad_i        (isLoad_i),
    .isStore_i       (isStore_i),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .spaceStall_o    (spaceStall)
  );

  // Recovery and back-pressure block acceptance but do not stall the front end
  assign stallFrontEnd_o = spaceStall;
  assign backEndReady_o  = renameReady_i & ~spaceStall & ~flagRecoverEX_i & ~stall_i;

  dispatchLatch latch_i (
    .clk           (clk),
    .rstN_i        (rstN_i),
    .load_i        (backEndReady_o),
    .hold_i        (stall_i),
    .pc_i          (pc_i),
    .opcode_i      (opcode_i),
    .imm_i         (imm_i),
    .logDest_i     (logDest_i),
    .physSrc1_i    (physSrc1_i),
    .physSrc2_i    (physSrc2_i),
    .physDest_i    (physDest_i),
    .physOldDest_i (physOldDest_i),
    .ckptId_i      (ckptId_i),
    .branchMask_i  (updatedBranchMask_o),
    .isLoad_i      (isLoad_i),
    .isStore_i     (isStore_i),
    .valid_o       (dispatchValid_o),
    .pc_o          (pc_o),
    .opcode_o      (opcode_o),
    .imm_o         (imm_o),
    .logDest_o     (logDest_o),
    .physSrc1_o    (physSrc1_o),
    .physSrc2_o    (physSrc2_o),
    .physDest_o    (physDest_o),
    .physOldDest_o (physOldDest_o),
    .ckptId_o      (ckptId_o),
    .branchMask_o  (branchMask_o),
    .isLoad_o      (isLoad_o),
    .isStore_o     (isStore_o)
  );

endmodule

// File: logic/dispatchLatch.sv
// Holds one group only; hold_i freezes contents and valid, and reset zeroes the fields
`timescale 1ns/1ps

module dispatchLatch (
  input  logic                     clk,
  input  logic                     rstN_i,
  input  logic                     load_i,  // Group accepted this cycle
  input  logic                     hold_i,  // Back end not taking the current group
  input  dispatchPkg::pc_t         pc_i          [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::opcode_t     opcode_i      [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::imm_t        imm_i         [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::logReg_t     logDest_i     [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::physReg_t    physSrc1_i    [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::physReg_t    physSrc2_i    [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::physReg_t    physDest_i    [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::physReg_t    physOldDest_i [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::ckptId_t     ckptId_i      [dispatchPkg::DISPATCH_WIDTH],
  input  dispatchPkg::branchMask_t branchMask_i  [dispatchPkg::DISPATCH_WIDTH],  // Already updated
  input  logic                     isLoad_i      [dispatchPkg::DISPATCH_WIDTH],
  input  logic                     isStore_i     [dispatchPkg::DISPATCH_WIDTH],
  output logic                     valid_o,
  output dispatchPkg::pc_t         pc_o          [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::opcode_t     opcode_o      [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::imm_t        imm_o         [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::logReg_t     logDest_o     [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::physReg_t    physSrc1_o    [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::physReg_t    physSrc2_o    [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::physReg_t    physDest_o    [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::physReg_t    physOldDest_o [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::ckptId_t     ckptId_o      [dispatchPkg::DISPATCH_WIDTH],
  output dispatchPkg::branchMask_t branchMask_o  [dispatchPkg::DISPATCH_WIDTH],
  output logic                     isLoad_o      [dispatchPkg::DISPATCH_WIDTH],
  output logic                     isStore_o     [dispatchPkg::DISPATCH_WIDTH]
);

  always_ff @(posedge clk or negedge rstN_i) begin : validReg
    if (!rstN_i) begin
      valid_o <= 1'b0;
    end else if (!hold_i) begin
      valid_o <= load_i;  // Slot drains unless a new group comes in
    end
  end

  always_ff @(posedge clk or negedge rstN_i) begin : fieldReg
    if (!rstN_i) begin
      pc_o          <= '{default: '0};
      opcode_o      <= '{default: '0};
      imm_o         <= '{default: '0};
      logDest_o     <= '{default: '0};
      physSrc1_o    <= '{default: '0};
      physSrc2_o    <= '{default: '0};
      physDest_o    <= '{default: '0};
      physOldDest_o <= '{default: '0};
      ckptId_o      <= '{default: '0};
      branchMask_o  <= '{default: '0};
      isLoad_o      <= '{default: 1'b0};
      isStore_o     <= '{default: 1'b0};
    end else if (load_i && !hold_i) begin
      pc_o          <= pc_i;
      opcode_o      <= opcode_i;
      imm_o         <= imm_i;
      logDest_o     <= logDest_i;
      physSrc1_o    <= physSrc1_i;
      physSrc2_o    <= physSrc2_i;
      physDest_o    <= physDest_i;
      physOldDest_o <= physOldDest_i;
      ckptId_o      <= ckptId_i;
      branchMask_o  <= branchMask_i;
      isLoad_o      <= isLoad_i;
      isStore_o     <= isStore_i;
    end
  end

  // The top must never accept a group while the back end is stalled
  noLoadWhileHeld: assert property (@(posedge clk) disable iff (!rstN_i)
    !(load_i && hold_i))
    else $error("[FAIL] load_i=%0h with hold_i=%0h", load_i, hold_i);

endmodule

// File: logic/dispatchPkg.sv
// Assumes four lanes, power-of-two queue capacities and occupancy counts that never exceed capacity
package dispatchPkg;

  // Group and checkpoint sizes
  localparam int DISPATCH_WIDTH  = 4;   // Lanes per group
  localparam int CHECKPOINTS     = 4;   // One mask bit per checkpoint
  localparam int CKPT_LOG        = 2;   // Enough to name every checkpoint

  // Back-end capacities
  localparam int SIZE_LSQ        = 16;  // Load queue and store queue each
  localparam int SIZE_ISSUEQ     = 32;
  localparam int SIZE_ACTIVELIST = 64;

  // Instruction field widths
  localparam int PC_W            = 32;
  localparam int OPCODE_W        = 8;
  localparam int IMM_W           = 16;
  localparam int PHYS_LOG        = 6;   // Physical register tag
  localparam int LOG_REG_LOG     = 5;   // Architectural register number

  // Occupancy counts run from zero up to and including the capacity
  localparam int LSQ_CNT_W       = $clog2(SIZE_LSQ) + 1;
  localparam int IQ_CNT_W        = $clog2(SIZE_ISSUEQ) + 1;
  localparam int AL_CNT_W        = $clog2(SIZE_ACTIVELIST) + 1;
  localparam int LANE_CNT_W      = $clog2(DISPATCH_WIDTH) + 1;  // Counts 0..DISPATCH_WIDTH

  // Per-lane payload fields
  typedef logic [PC_W-1:0]        pc_t;
  typedef logic [OPCODE_W-1:0]    opcode_t;
  typedef logic [IMM_W-1:0]       imm_t;
  typedef logic [PHYS_LOG-1:0]    physReg_t;
  typedef logic [LOG_REG_LOG-1:0] logReg_t;

  // Branch speculation tracking
  typedef logic [CKPT_LOG-1:0]    ckptId_t;
  typedef logic [CHECKPOINTS-1:0] branchMask_t;  // Bit set while the checkpoint is unresolved

  // Occupancy and group counts
  typedef logic [LSQ_CNT_W-1:0]   lsqCnt_t;   // 5 bits
  typedef logic [IQ_CNT_W-1:0]    iqCnt_t;    // 6 bits
  typedef logic [AL_CNT_W-1:0]    alCnt_t;    // 7 bits
  typedef logic [LANE_CNT_W-1:0]  laneCnt_t;  // 3 bits

endpackage

// File: sim.f
+incdir+tb
logic/dispatchPkg.sv
logic/branchMaskUpdate.sv
logic/backEndSpaceCheck.sv
logic/dispatchLatch.sv
logic/dispatch.sv
tb/dispatchTb.sv

// File: tb/dispatchTests.svh
// Tests run in order from dispatchTb; each one expects rename idle and no back-end stall on entry

task automatic resetTest();
  @(negedge clk);
  compareValue("dispatchValid_o", 32'(dispatchValid), 32'h0);
  compareValue("backEndReady_o", 32'(backEndReady), 32'h0);  // Rename has no group yet
  for (int l = 0; l < LANES; l++) begin
    compareValue($sformatf("pc_o[%0d]", l), 32'(pcQ[l]), 32'h0);
  end
endtask

task automatic passThroughTest();
  sendGroup(1'b0, 1'b0);
  verifyLatched();
  @(negedge clk);
  compareValue("dispatchValid_o", 32'(dispatchValid), 32'h0);  // No new group, slot drains
endtask

// Random checkpoint ids, so different bits get cleared
task automatic maskClearTest();
  repeat (3) begin
    sendGroup(1'b1, 1'b0);
    verifyLatched();
  end
endtask

// Lanes 0 and 1 load, lane 2 stores, lane 3 is neither
task automatic probeCapacity(input int lq, input int sq, input int iq, input int al,
                             input logic expectStall);
  @(posedge clk);
  randomizeGroup();
  for (int l = 0; l < LANES; l++) begin
    isLoad[l]  <= (l < 2);
    isStore[l] <= (l == 2);
  end
  lqCnt       <= dispatchPkg::lsqCnt_t'(lq);
  sqCnt       <= dispatchPkg::lsqCnt_t'(sq);
  iqCnt       <= dispatchPkg::iqCnt_t'(iq);
  alCnt       <= dispatchPkg::alCnt_t'(al);
  renameReady <= 1'b1;
  @(negedge clk);
  compareValue("stallFrontEnd_o", 32'(stallFrontEnd), 32'(expectStall));
  compareValue("backEndReady_o", 32'(backEndReady), 32'(!expectStall));
  @(posedge clk);
  renameReady <= 1'b0;
  if (expectStall) begin
    @(negedge clk);
    compareValue("dispatchValid_o", 32'(dispatchValid), 32'h0);
  end else begin
    waitValid();
  end
endtask

task automatic capacityTest();
  probeCapacity(dispatchPkg::SIZE_LSQ - 2, 0, 0, 0, 1'b0);  // Two loads fill the queue
  probeCapacity(dispatchPkg::SIZE_LSQ - 1, 0, 0, 0, 1'b1);
  probeCapacity(0, dispatchPkg::SIZE_LSQ - 1, 0, 0, 1'b0);  // One store
  probeCapacity(0, dispatchPkg::SIZE_LSQ, 0, 0, 1'b1);
  probeCapacity(0, 0, dispatchPkg::SIZE_ISSUEQ - LANES, 0, 1'b0);
  probeCapacity(0, 0, dispatchPkg::SIZE_ISSUEQ - LANES + 1, 0, 1'b1);
  probeCapacity(0, 0, 0, dispatchPkg::SIZE_ACTIVELIST - LANES, 1'b0);
  probeCapacity(0, 0, 0, dispatchPkg::SIZE_ACTIVELIST - LANES + 1, 1'b1);
  @(posedge clk);
  lqCnt <= '0;
  sqCnt <= '0;
  iqCnt <= '0;
  alCnt <= '0;
endtask

task automatic recoveryTest();
  @(posedge clk);
  randomizeGroup();
  flagRecover <= 1'b1;
  renameReady <= 1'b1;
  @(negedge clk);
  compareValue("backEndReady_o", 32'(backEndReady), 32'h0);
  compareValue("stallFrontEnd_o", 32'(stallFrontEnd), 32'h0);  // Not a space problem
  @(posedge clk);
  flagRecover <= 1'b0;
  renameReady <= 1'b0;
  @(negedge clk);
  compareValue("dispatchValid_o", 32'(dispatchValid), 32'h0);
endtask

task automatic backPressureTest();
  sendGroup(1'b1, 1'b1);  // stall_i rises on the acceptance edge
  verifyLatched();
  @(posedge clk);
  for (int l = 0; l < LANES; l++) begin
    branchMask[l] <= ~branchMask[l];  // A different group waits at rename
  end
  renameReady <= 1'b1;
  repeat (4) begin
    @(negedge clk);
    compareValue("backEndReady_o", 32'(backEndReady), 32'h0);
    compareValue("stallFrontEnd_o", 32'(stallFrontEnd), 32'h0);
    compareValue("dispatchValid_o", 32'(dispatchValid), 32'h1);
    verifyLatched();
  end
  @(posedge clk);
  stall       <= 1'b0;
  renameReady <= 1'b0;
  sendGroup(1'b0, 1'b0);  // Next group flows once the back end frees up
  verifyLatched();
endtask

// File: tb/dispatchTb.sv
// One group in flight at a time; inputs change on rising edges and outputs are sampled on falling edges
`timescale 1ns/1ps

module dispatchTb;

  localparam int LANES         = dispatchPkg::DISPATCH_WIDTH;
  localparam int VALID_TIMEOUT = 8;  // Cycles allowed for dispatchValid_o to rise

  logic                     clk = 1'b0;
  logic                     rstN;
  logic                     stall;
  logic                     renameReady;
  logic                     flagRecover;
  logic                     ctrlVerified;
  dispatchPkg::ckptId_t     ctrlVerifiedId;
  dispatchPkg::pc_t         pc          [LANES];
  dispatchPkg::opcode_t     opcode      [LANES];
  dispatchPkg::imm_t        imm         [LANES];
  dispatchPkg::logReg_t     logDest     [LANES];
  dispatchPkg::physReg_t    physSrc1    [LANES];
  dispatchPkg::physReg_t    physSrc2    [LANES];
  dispatchPkg::physReg_t    physDest    [LANES];
  dispatchPkg::physReg_t    physOldDest [LANES];
  dispatchPkg::ckptId_t     ckptId      [LANES];
  dispatchPkg::branchMask_t branchMask  [LANES];
  logic                     isLoad      [LANES];
  logic                     isStore     [LANES];
  dispatchPkg::lsqCnt_t     lqCnt;
  dispatchPkg::lsqCnt_t     sqCnt;
  dispatchPkg::iqCnt_t      iqCnt;
  dispatchPkg::alCnt_t      alCnt;

  logic                     backEndReady;
  logic                     stallFrontEnd;
  logic                     dispatchValid;
  dispatchPkg::branchMask_t updatedMask  [LANES];  // Combinational mask back to rename
  dispatchPkg::pc_t         pcQ          [LANES];  // Latched lanes
  dispatchPkg::opcode_t     opcodeQ      [LANES];
  dispatchPkg::imm_t        immQ         [LANES];
  dispatchPkg::logReg_t     logDestQ     [LANES];
  dispatchPkg::physReg_t    physSrc1Q    [LANES];
  dispatchPkg::physReg_t    physSrc2Q    [LANES];
  dispatchPkg::physReg_t    physDestQ    [LANES];
  dispatchPkg::physReg_t    physOldDestQ [LANES];
  dispatchPkg::ckptId_t     ckptIdQ      [LANES];
  dispatchPkg::branchMask_t branchMaskQ  [LANES];
  logic                     isLoadQ      [LANES];
  logic                     isStoreQ     [LANES];

  dispatchPkg::branchMask_t expMask [LANES];  // Mask each lane should carry after the update
  int errors   = 0;
  int timeouts = 0;

  always #10 clk = ~clk;  // 20 ns period

  dispatch dut_i (
    .clk                 (clk),
    .rstN_i              (rstN),
    .stall_i             (stall),
    .renameReady_i       (renameReady),
    .flagRecoverEX_i     (flagRecover),
    .ctrlVerified_i      (ctrlVerified),
    .ctrlVerifiedId_i    (ctrlVerifiedId),
    .pc_i                (pc),
    .opcode_i            (opcode),
    .imm_i               (imm),
    .logDest_i           (logDest),
    .physSrc1_i          (physSrc1),
    .physSrc2_i          (physSrc2),
    .physDest_i          (physDest),
    .physOldDest_i       (physOldDest),
    .ckptId_i            (ckptId),
    .branchMask_i        (branchMask),
    .isLoad_i            (isLoad),
    .isStore_i           (isStore),
    .loadQueueCnt_i      (lqCnt),
    .storeQueueCnt_i     (sqCnt),
    .issueQueueCnt_i     (iqCnt),
    .activeListCnt_i     (alCnt),
    .backEndReady_o      (backEndReady),
    .stallFrontEnd_o     (stallFrontEnd),
    .updatedBranchMask_o (updatedMask),
    .dispatchValid_o     (dispatchValid),
    .pc_o                (pcQ),
    .opcode_o            (opcodeQ),
    .imm_o               (immQ),
    .logDest_o           (logDestQ),
    .physSrc1_o          (physSrc1Q),
    .physSrc2_o          (physSrc2Q),
    .physDest_o          (physDestQ),
    .physOldDest_o       (physOldDestQ),
    .ckptId_o            (ckptIdQ),
    .branchMask_o        (branchMaskQ),
    .isLoad_o            (isLoadQ),
    .isStore_o           (isStoreQ)
  );

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    valueMatch: assert (got === expected)
      else begin
        errors++;
        $display("[FAIL] %s = %0h, expected %0h", name, got, expected);
      end
  endtask

  // New random payload; each lane is a load, a store or neither
  task automatic randomizeGroup();
    int unsigned kind;
    for (int l = 0; l < LANES; l++) begin
      kind            = $urandom % 3;
      pc[l]          <= dispatchPkg::pc_t'($urandom);
      opcode[l]      <= dispatchPkg::opcode_t'($urandom);
      imm[l]         <= dispatchPkg::imm_t'($urandom);
      logDest[l]     <= dispatchPkg::logReg_t'($urandom);
      physSrc1[l]    <= dispatchPkg::physReg_t'($urandom);
      physSrc2[l]    <= dispatchPkg::physReg_t'($urandom);
      physDest[l]    <= dispatchPkg::physReg_t'($urandom);
      physOldDest[l] <= dispatchPkg::physReg_t'($urandom);
      ckptId[l]      <= dispatchPkg::ckptId_t'($urandom);
      branchMask[l]  <= dispatchPkg::branchMask_t'($urandom);
      isLoad[l]      <= (kind == 1);
      isStore[l]     <= (kind == 2);
    end
  endtask

  // Latched lanes must match the driven group, masks as updated at acceptance
  task automatic verifyLatched();
    string sfx;
    for (int l = 0; l < LANES; l++) begin
      sfx = $sformatf("[%0d]", l);
      compareValue({"pc_o", sfx}, 32'(pcQ[l]), 32'(pc[l]));
      compareValue({"opcode_o", sfx}, 32'(opcodeQ[l]), 32'(opcode[l]));
      compareValue({"imm_o", sfx}, 32'(immQ[l]), 32'(imm[l]));
      compareValue({"logDest_o", sfx}, 32'(logDestQ[l]), 32'(logDest[l]));
      compareValue({"physSrc1_o", sfx}, 32'(physSrc1Q[l]), 32'(physSrc1[l]));
      compareValue({"physSrc2_o", sfx}, 32'(physSrc2Q[l]), 32'(physSrc2[l]));
      compareValue({"physDest_o", sfx}, 32'(physDestQ[l]), 32'(physDest[l]));
      compareValue({"physOldDest_o", sfx}, 32'(physOldDestQ[l]), 32'(physOldDest[l]));
      compareValue({"ckptId_o", sfx}, 32'(ckptIdQ[l]), 32'(ckptId[l]));
      compareValue({"branchMask_o", sfx}, 32'(branchMaskQ[l]), 32'(expMask[l]));
      compareValue({"isLoad_o", sfx}, 32'(isLoadQ[l]), 32'(isLoad[l]));
      compareValue({"isStore_o", sfx}, 32'(isStoreQ[l]), 32'(isStore[l]));
    end
  endtask

  // Valid should already be up on the first falling edge after acceptance
  task automatic waitValid();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!dispatchValid && waited < VALID_TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (!dispatchValid) begin
      timeouts++;
      $display("dispatchValid_o did not rise within %0d cycles of acceptance", VALID_TIMEOUT);
    end else begin
      compareValue("dispatchValid_o delay", 32'(waited), 32'h0);
    end
  endtask

  // Presents a random group, checks the combinational outputs and waits until it is latched
  task automatic sendGroup(input logic verify, input logic holdAfter);
    @(posedge clk);
    randomizeGroup();
    ctrlVerified   <= verify;
    ctrlVerifiedId <= dispatchPkg::ckptId_t'($urandom);
    renameReady    <= 1'b1;
    @(negedge clk);
    for (int l = 0; l < LANES; l++) begin
      expMask[l] = branchMask[l];
      if (ctrlVerified) begin
        expMask[l][ctrlVerifiedId] = 1'b0;  // Verified checkpoint no longer guards the lane
      end
      compareValue($sformatf("updatedBranchMask_o[%0d]", l), 32'(updatedMask[l]),
                   32'(expMask[l]));
    end
    compareValue("backEndReady_o", 32'(backEndReady), 32'h1);
    @(posedge clk);
    renameReady  <= 1'b0;  // Acceptance edge
    ctrlVerified <= 1'b0;
    stall        <= holdAfter;
    waitValid();
  endtask

  `include "dispatchTests.svh"

  initial begin : mainSeq
    void'($urandom(32'h9031));  // Single seed for the whole run
    randomizeGroup();
    rstN           <= 1'b0;
    stall          <= 1'b0;
    renameReady    <= 1'b0;
    flagRecover    <= 1'b0;
    ctrlVerified   <= 1'b0;
    ctrlVerifiedId <= '0;
    lqCnt          <= '0;
    sqCnt          <= '0;
    iqCnt          <= '0;
    alCnt          <= '0;
    repeat (16) @(posedge clk);
    rstN <= 1'b1;
    resetTest();
    passThroughTest();
    maskClearTest();
    capacityTest();
    recoveryTest();
    backPressureTest();
    $display("Checks failed: %0d, wait timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
